//--- hdl/csr_pkg.sv
// ----------------------------------------------------------
// Machine CSR package
// Shared types, CSR addresses, reset values, read-only masks
// and event indices of the machine-mode CSR unit
// ----------------------------------------------------------
`default_nettype none

package csr_pkg;

   // ----------------------------------------------------------
   // Widths and types
   // ----------------------------------------------------------
   localparam int XLEN          = 32;
   localparam int EV_SEL_SZ     = 5;
   localparam int NUM_EVENTS    = 24;
   localparam int NUM_RET_CLASS = 13;

   typedef logic [XLEN-1:0]          csr_word_t;
   typedef logic [11:0]              csr_addr_t;
   typedef logic [EV_SEL_SZ-1:0]     ev_sel_t;
   typedef logic [NUM_EVENTS-1:0]    hpm_events_t;
   typedef logic [NUM_RET_CLASS-1:0] ret_class_t;
   typedef logic [3:0]               ecause_t;

   // Retire class bit positions in ret_class_t
   localparam int RET_LD   = 0;
   localparam int RET_ST   = 1;
   localparam int RET_CSR  = 2;
   localparam int RET_SYS  = 3;
   localparam int RET_ALU  = 4;
   localparam int RET_BR   = 5;
   localparam int RET_JAL  = 6;
   localparam int RET_JALR = 7;
   localparam int RET_MUL  = 8;
   localparam int RET_DIV  = 9;
   localparam int RET_REM  = 10;
   localparam int RET_HINT = 11;
   localparam int RET_UNK  = 12;

   // Event indices, events 1..13 follow the retire classes
   localparam int EV_NONE       = 0;
   localparam int EV_RET_BASE   = 1;
   localparam int EV_IADDR_MIS  = 14;
   localparam int EV_IACC_FAULT = 15;
   localparam int EV_ILLEGAL    = 16;
   localparam int EV_BRANCH     = 17;
   localparam int EV_MISALIGN   = 18;
   localparam int EV_RETIRED    = 19;
   localparam int EV_BREAK      = 20;
   localparam int EV_ST_MIS     = 21;
   localparam int EV_ECALL      = 22;
   localparam int EV_EXT_IRQ    = 23;

   // ----------------------------------------------------------
   // Machine CSR addresses
   // ----------------------------------------------------------
   localparam csr_addr_t ADDR_MSTATUS           = 12'h300;
   localparam csr_addr_t ADDR_MISA              = 12'h301;
   localparam csr_addr_t ADDR_MIE               = 12'h304;
   localparam csr_addr_t ADDR_MTVEC             = 12'h305;
   localparam csr_addr_t ADDR_MCOUNTINHIBIT     = 12'h320;
   localparam csr_addr_t ADDR_MHPMEVENT_BASE    = 12'h323;
   localparam csr_addr_t ADDR_MSCRATCH          = 12'h340;
   localparam csr_addr_t ADDR_MEPC              = 12'h341;
   localparam csr_addr_t ADDR_MCAUSE            = 12'h342;
   localparam csr_addr_t ADDR_MTVAL             = 12'h343;
   localparam csr_addr_t ADDR_MIP               = 12'h344;
   localparam csr_addr_t ADDR_MCYCLE            = 12'hB00;
   localparam csr_addr_t ADDR_MINSTRET          = 12'hB02;
   localparam csr_addr_t ADDR_MHPMCOUNTER_BASE  = 12'hB03;
   localparam csr_addr_t ADDR_MCYCLEH           = 12'hB80;
   localparam csr_addr_t ADDR_MINSTRETH         = 12'hB82;
   localparam csr_addr_t ADDR_MHPMCOUNTERH_BASE = 12'hB83;

   // ----------------------------------------------------------
   // Reset values and read-only masks
   // ----------------------------------------------------------
   // mstatus resets with mpp = machine, writable mpp, mpie, mie
   localparam csr_word_t MSTATUS_INIT = 32'h0000_1800;
   localparam csr_word_t MSTATUS_RO   = 32'hFFFF_E777;
   // MXL = 32 bit, extensions I and M
   localparam csr_word_t MISA_INIT    = 32'h4000_1100;
   // Only direct and vectored modes, so bit 1 stays clear
   localparam csr_word_t MTVEC_INIT   = 32'h0000_0100;
   localparam csr_word_t MTVEC_RO     = 32'h0000_0002;
   localparam csr_word_t MEPC_RO      = 32'h0000_0001;
   // Software, timer and external bits only
   localparam csr_word_t MIE_RO       = 32'hFFFF_F777;
   localparam csr_word_t MIP_RO       = 32'hFFFF_F777;

   // Bit 1 has no counter, bits above the last counter are fixed
   function automatic csr_word_t MINHIBIT_RO(input int num_hpm);
      return (csr_word_t'('1) << (num_hpm + 3)) | csr_word_t'(2);
   endfunction

endpackage

`default_nettype wire

//--- hdl/csr_bus_if.sv
// ----------------------------------------------------------
// CSR access bus
// Write strobe and read address from the top level to the
// two register banks
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface csr_bus_if
   import csr_pkg::*;
();

   // Single-cycle write strobe with address and data
   logic      wr_en;
   csr_addr_t wr_addr;
   csr_word_t wr_data;

   // Read address, banks answer combinationally
   csr_addr_t rd_addr;

   modport bank (
      input wr_en,
      input wr_addr,
      input wr_data,
      input rd_addr
   );

endinterface

`default_nettype wire

//--- hdl/csr_field_reg.sv
// ----------------------------------------------------------
// CSR field register
// One storage element with reset value and read-only mask,
// generic in its payload type
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module csr_field_reg #(
   parameter type    field_t = logic [31:0],
   parameter field_t INIT    = '0,
   parameter field_t RO_MASK = '0
) (
   input  wire logic   clk,
   input  wire logic   reset,
   input  wire logic   wr_en,
   input  wire field_t wr_data,
   output field_t      q
);

   // Read-only bits only ever hold INIT, so keeping q keeps INIT
   always_ff @(posedge clk)
   begin
      if (reset)
         q <= INIT;
      else if (wr_en)
         q <= (wr_data & ~RO_MASK) | (q & RO_MASK);
   end

endmodule

`default_nettype wire

//--- hdl/csr_event_decode.sv
// ----------------------------------------------------------
// Performance event decode
// Turns retire classes and exception causes into the
// 24-bit per-cycle event vector and the retire pulse
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module csr_event_decode
   import csr_pkg::*;
(
   input  wire ret_class_t ret_class,
   input  wire logic       e_flag,
   input  wire ecause_t    e_cause,
   input  wire logic       ext_irq,
   output hpm_events_t     hpm_events,
   output logic            total_retired
);

   // One-hot exception cause, all zero without e_flag
   logic [15:0] cause_hit;

   assign cause_hit = e_flag ? (16'h0001 << e_cause) : 16'h0000;

   // At most one instruction retires per cycle, so an OR is enough
   assign total_retired = |ret_class;

   always_comb
   begin
      // Event 0 never counts
      hpm_events[EV_NONE] = 1'b0;
      // Retire classes in package order
      hpm_events[EV_RET_BASE +: NUM_RET_CLASS] = ret_class;
      // Instruction misaligned, access fault, illegal instruction
      hpm_events[EV_IADDR_MIS]  = cause_hit[0];
      hpm_events[EV_IACC_FAULT] = cause_hit[1];
      hpm_events[EV_ILLEGAL]    = cause_hit[2];
      // Any control transfer
      hpm_events[EV_BRANCH]     = ret_class[RET_BR] | ret_class[RET_JAL] |
                                  ret_class[RET_JALR];
      // Instruction, load or store address misaligned
      hpm_events[EV_MISALIGN]   = cause_hit[0] | cause_hit[4] | cause_hit[6];
      hpm_events[EV_RETIRED]    = total_retired;
      // Breakpoint, store misaligned, ecall from user mode
      hpm_events[EV_BREAK]      = cause_hit[3];
      hpm_events[EV_ST_MIS]     = cause_hit[6];
      hpm_events[EV_ECALL]      = cause_hit[8];
      hpm_events[EV_EXT_IRQ]    = ext_irq;
   end

endmodule

`default_nettype wire

//--- hdl/csr_machine_regs.sv
// ----------------------------------------------------------
// Machine trap CSRs and event selectors
// Write decode, storage and combinational read hit for the
// trap registers, mcountinhibit and mhpmevent selectors
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module csr_machine_regs
   import csr_pkg::*;
#(
   parameter int NUM_HPM = 4
) (
   input  wire logic              clk,
   input  wire logic              reset,
   csr_bus_if.bank                bus,
   output logic                   rd_hit,
   output csr_word_t              rd_data,
   output csr_word_t              minhibit,
   output ev_sel_t [NUM_HPM-1:0]  ev_sel
);

   // ----------------------------------------------------------
   // Register table
   // ----------------------------------------------------------
   localparam int NUM_WORDS    = 10;
   localparam int IDX_MINHIBIT = 9;

   localparam csr_addr_t WORD_ADDR [NUM_WORDS] = '{
      ADDR_MSTATUS, ADDR_MISA, ADDR_MIE, ADDR_MTVEC, ADDR_MSCRATCH,
      ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL, ADDR_MIP, ADDR_MCOUNTINHIBIT
   };

   localparam csr_word_t WORD_INIT [NUM_WORDS] = '{
      MSTATUS_INIT, MISA_INIT, 32'h0, MTVEC_INIT, 32'h0,
      32'h0, 32'h0, 32'h0, 32'h0, 32'h0
   };

   // misa is a constant, mscratch, mcause and mtval fully writable
   localparam csr_word_t WORD_RO [NUM_WORDS] = '{
      MSTATUS_RO, 32'hFFFF_FFFF, MIE_RO, MTVEC_RO, 32'h0,
      MEPC_RO, 32'h0, 32'h0, MIP_RO, MINHIBIT_RO(NUM_HPM)
   };

   csr_word_t word_q [NUM_WORDS];

   // ----------------------------------------------------------
   // Storage
   // ----------------------------------------------------------
   for (genvar i = 0; i < NUM_WORDS; i++)
   begin : g_word
      csr_field_reg #(
         .field_t (csr_word_t),
         .INIT    (WORD_INIT[i]),
         .RO_MASK (WORD_RO[i])
      ) u_reg (
         .clk     (clk),
         .reset   (reset),
         .wr_en   (bus.wr_en && (bus.wr_addr == WORD_ADDR[i])),
         .wr_data (bus.wr_data),
         .q       (word_q[i])
      );
   end

   // 5-bit selectors, one per performance counter
   for (genvar n = 0; n < NUM_HPM; n++)
   begin : g_sel
      csr_field_reg #(
         .field_t (ev_sel_t),
         .INIT    (ev_sel_t'(0)),
         .RO_MASK (ev_sel_t'(0))
      ) u_sel (
         .clk     (clk),
         .reset   (reset),
         .wr_en   (bus.wr_en && (bus.wr_addr == csr_addr_t'(ADDR_MHPMEVENT_BASE + n))),
         .wr_data (bus.wr_data[EV_SEL_SZ-1:0]),
         .q       (ev_sel[n])
      );
   end

   assign minhibit = word_q[IDX_MINHIBIT];

   // ----------------------------------------------------------
   // Read hit and data
   // ----------------------------------------------------------
   always_comb
   begin
      rd_hit  = 1'b0;
      rd_data = '0;
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         if (bus.rd_addr == WORD_ADDR[i])
         begin
            rd_hit  = 1'b1;
            rd_data = word_q[i];
         end
      end
      // Selectors read back zero-extended
      for (int n = 0; n < NUM_HPM; n++)
      begin
         if (bus.rd_addr == csr_addr_t'(ADDR_MHPMEVENT_BASE + n))
         begin
            rd_hit  = 1'b1;
            rd_data = csr_word_t'(ev_sel[n]);
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/csr_counters.sv
// ----------------------------------------------------------
// Machine counters
// 64-bit mcycle, minstret and performance counters with
// inhibit, half-word writes and combinational reads
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module csr_counters
   import csr_pkg::*;
#(
   parameter int NUM_HPM = 4
) (
   input  wire logic                  clk,
   input  wire logic                  reset,
   csr_bus_if.bank                    bus,
   input  wire hpm_events_t           hpm_events,
   input  wire logic                  total_retired,
   input  wire csr_word_t             minhibit,
   input  wire ev_sel_t [NUM_HPM-1:0] ev_sel,
   output logic                       rd_hit,
   output csr_word_t                  rd_data
);

   // Counter 0 is mcycle, 1 is minstret, then the hpm counters
   localparam int NUM_CNT = NUM_HPM + 2;

   // Offset from mcycle, also the counter's inhibit bit
   function automatic int cnt_slot(input int i);
      return (i == 0) ? 0 : i + 1;
   endfunction

   function automatic csr_addr_t lo_addr(input int i);
      case (i)
         0:       return ADDR_MCYCLE;
         1:       return ADDR_MINSTRET;
         default: return csr_addr_t'(ADDR_MHPMCOUNTER_BASE + i - 2);
      endcase
   endfunction

   function automatic csr_addr_t hi_addr(input int i);
      case (i)
         0:       return ADDR_MCYCLEH;
         1:       return ADDR_MINSTRETH;
         default: return csr_addr_t'(ADDR_MHPMCOUNTERH_BASE + i - 2);
      endcase
   endfunction

   logic [NUM_CNT-1:0][2*XLEN-1:0] cnt;
   logic [NUM_CNT-1:0]             wr_lo;
   logic [NUM_CNT-1:0]             wr_hi;
   logic [NUM_CNT-1:0]             inc;
   // Event vector padded to the full selector range
   logic [2**EV_SEL_SZ-1:0]        ev_all;

   assign ev_all = {{(2**EV_SEL_SZ-NUM_EVENTS){1'b0}}, hpm_events};

   // ----------------------------------------------------------
   // Write decode and increment sources
   // ----------------------------------------------------------
   always_comb
   begin
      for (int i = 0; i < NUM_CNT; i++)
      begin
         wr_lo[i] = bus.wr_en && (bus.wr_addr == lo_addr(i));
         wr_hi[i] = bus.wr_en && (bus.wr_addr == hi_addr(i));
      end
      inc[0] = 1'b1;
      inc[1] = total_retired;
      // Unused selector values point at zero padding
      for (int n = 0; n < NUM_HPM; n++)
         inc[n+2] = ev_all[ev_sel[n]];
   end

   // A write to either half replaces it and skips that cycle's increment
   always_ff @(posedge clk)
   begin
      if (reset)
         cnt <= '0;
      else
      begin
         for (int i = 0; i < NUM_CNT; i++)
         begin
            if (wr_lo[i])
               cnt[i][XLEN-1:0] <= bus.wr_data;
            else if (wr_hi[i])
               cnt[i][2*XLEN-1:XLEN] <= bus.wr_data;
            else if (inc[i] && !minhibit[cnt_slot(i)])
               cnt[i] <= cnt[i] + 1'b1;
         end
      end
   end

   // ----------------------------------------------------------
   // Read of low and high halves
   // ----------------------------------------------------------
   always_comb
   begin
      rd_hit  = 1'b0;
      rd_data = '0;
      for (int i = 0; i < NUM_CNT; i++)
      begin
         if (bus.rd_addr == lo_addr(i))
         begin
            rd_hit  = 1'b1;
            rd_data = cnt[i][XLEN-1:0];
         end
         else if (bus.rd_addr == hi_addr(i))
         begin
            rd_hit  = 1'b1;
            rd_data = cnt[i][2*XLEN-1:XLEN];
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/csr_read_port.sv
// ----------------------------------------------------------
// CSR read port
// Picks the hitting bank and registers the read result,
// flagging addresses that no bank implements
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module csr_read_port
   import csr_pkg::*;
#(
   parameter int NUM_HPM = 4
) (
   input  wire logic      clk,
   input  wire logic      reset,
   input  wire logic      rd_en,
   input  wire logic      regs_hit,
   input  wire csr_word_t regs_data,
   input  wire logic      cnt_hit,
   input  wire csr_word_t cnt_data,
   output logic           rd_valid,
   output csr_word_t      rd_data,
   output logic           rd_illegal
);

   if (NUM_HPM < 1 || NUM_HPM > 29)
   begin : g_bad_num_hpm
      $error("NUM_HPM must be in 1..29");
   end

   csr_word_t sel_data;
   logic      any_hit;

   // Banks never overlap, zero when nothing hits
   assign any_hit  = regs_hit || cnt_hit;
   assign sel_data = regs_hit ? regs_data :
                     cnt_hit  ? cnt_data  : '0;

   // Status flags pulse with the read
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd_valid   <= 1'b0;
         rd_illegal <= 1'b0;
      end
      else
      begin
         rd_valid   <= rd_en;
         rd_illegal <= rd_en && !any_hit;
      end
   end

   // Data holds between reads
   always_ff @(posedge clk)
   begin
      if (rd_en)
         rd_data <= sel_data;
   end

endmodule

`default_nettype wire

//--- hdl/csr_unit.sv
// ----------------------------------------------------------
// Machine-mode CSR unit
// Trap CSRs, counters and event decode behind a simple
// strobe-based CSR access port
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module csr_unit
   import csr_pkg::*;
#(
   parameter int NUM_HPM = 4
) (
   input  wire logic       clk,
   input  wire logic       reset,
   // CSR access port
   input  wire logic       wr_en,
   input  wire csr_addr_t  wr_addr,
   input  wire csr_word_t  wr_data,
   input  wire logic       rd_en,
   input  wire csr_addr_t  rd_addr,
   output logic            rd_valid,
   output csr_word_t       rd_data,
   output logic            rd_illegal,
   // Pipeline events of this cycle
   input  wire ret_class_t ret_class,
   input  wire logic       e_flag,
   input  wire ecause_t    e_cause,
   input  wire logic       ext_irq
);

   csr_bus_if bus ();

   hpm_events_t           hpm_events;
   logic                  total_retired;
   csr_word_t             minhibit;
   ev_sel_t [NUM_HPM-1:0] ev_sel;
   logic                  regs_hit;
   csr_word_t             regs_data;
   logic                  cnt_hit;
   csr_word_t             cnt_data;

   assign bus.wr_en   = wr_en;
   assign bus.wr_addr = wr_addr;
   assign bus.wr_data = wr_data;
   assign bus.rd_addr = rd_addr;

   // ----------------------------------------------------------
   // Event decode, register banks and read port
   // ----------------------------------------------------------
   csr_event_decode u_event_decode (
      .ret_class     (ret_class),
      .e_flag        (e_flag),
      .e_cause       (e_cause),
      .ext_irq       (ext_irq),
      .hpm_events    (hpm_events),
      .total_retired (total_retired)
   );

   csr_machine_regs #(.NUM_HPM(NUM_HPM)) u_machine_regs (
      .clk      (clk),
      .reset    (reset),
      .bus      (bus.bank),
      .rd_hit   (regs_hit),
      .rd_data  (regs_data),
      .minhibit (minhibit),
      .ev_sel   (ev_sel)
   );

   csr_counters #(.NUM_HPM(NUM_HPM)) u_counters (
      .clk           (clk),
      .reset         (reset),
      .bus           (bus.bank),
      .hpm_events    (hpm_events),
      .total_retired (total_retired),
      .minhibit      (minhibit),
      .ev_sel        (ev_sel),
      .rd_hit        (cnt_hit),
      .rd_data       (cnt_data)
   );

   csr_read_port #(.NUM_HPM(NUM_HPM)) u_read_port (
      .clk        (clk),
      .reset      (reset),
      .rd_en      (rd_en),
      .regs_hit   (regs_hit),
      .regs_data  (regs_data),
      .cnt_hit    (cnt_hit),
      .cnt_data   (cnt_data),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .rd_illegal (rd_illegal)
   );

endmodule

`default_nettype wire

//--- verif/csr_unit_checker.sv
// ----------------------------------------------------------
// CSR unit checker
// Concurrent assertions on the read port, the fixed bits of
// mtvec and mepc and the mcycle step, bound into csr_unit
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module csr_unit_checker
   import csr_pkg::*;
(
   input wire logic              clk,
   input wire logic              reset,
   input wire logic              wr_en,
   input wire csr_addr_t         wr_addr,
   input wire logic              rd_en,
   input wire csr_addr_t         rd_addr,
   input wire logic              rd_valid,
   input wire csr_word_t         rd_data,
   input wire logic              rd_illegal,
   input wire csr_word_t         minhibit,
   input wire logic [2*XLEN-1:0] mcycle
);

   // Write to either half of mcycle in this cycle
   logic mcycle_wr;

   assign mcycle_wr = wr_en && (wr_addr == ADDR_MCYCLE || wr_addr == ADDR_MCYCLEH);

   // ----------------------------------------------------------
   // Read port
   // ----------------------------------------------------------
   a_rd_valid_set : assert property (@(posedge clk) !reset && rd_en |=> rd_valid)
      else $error("rd_valid missing one cycle after rd_en");

   a_rd_valid_clear : assert property (@(posedge clk) !reset && !rd_en |=> !rd_valid)
      else $error("rd_valid set without a read strobe");

   a_illegal_zero : assert property (@(posedge clk) disable iff (reset)
      rd_illegal |-> rd_data == '0)
      else $error("rd_illegal set with nonzero rd_data");

   // ----------------------------------------------------------
   // Fixed bits of mtvec and mepc, seen through reads
   // ----------------------------------------------------------
   a_mtvec_bit1 : assert property (@(posedge clk)
      !reset && rd_en && rd_addr == ADDR_MTVEC |=> !rd_data[1])
      else $error("mtvec bit 1 read back as one");

   a_mepc_bit0 : assert property (@(posedge clk)
      !reset && rd_en && rd_addr == ADDR_MEPC |=> !rd_data[0])
      else $error("mepc bit 0 read back as one");

   // Free-running mcycle steps by exactly one
   a_mcycle_step : assert property (@(posedge clk)
      !reset && !minhibit[0] && !mcycle_wr |=> mcycle == $past(mcycle) + 64'd1)
      else $error("mcycle did not advance by one");

endmodule

bind csr_unit csr_unit_checker u_checker (
   .clk        (clk),
   .reset      (reset),
   .wr_en      (wr_en),
   .wr_addr    (wr_addr),
   .rd_en      (rd_en),
   .rd_addr    (rd_addr),
   .rd_valid   (rd_valid),
   .rd_data    (rd_data),
   .rd_illegal (rd_illegal),
   .minhibit   (minhibit),
   .mcycle     (u_counters.cnt[0])
);

`default_nettype wire

//--- verif/tb_csr_unit.sv
// ----------------------------------------------------------
// CSR unit testbench
// Trap CSR masks, illegal reads, mcycle, minstret and the
// performance counters against a reference model
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit
   import csr_pkg::*;
();

   localparam int NUM_HPM         = 4;
   // Tests take about 600 cycles
   localparam int WATCHDOG_CYCLES = 2000;
   localparam int TRAFFIC_CYCLES  = 150;
   // Load, any control transfer, misaligned, external interrupt
   localparam ev_sel_t HPM_SEL [NUM_HPM] = '{5'd1, 5'd17, 5'd18, 5'd23};

   logic       clk;
   logic       reset;
   logic       wr_en;
   csr_addr_t  wr_addr;
   csr_word_t  wr_data;
   logic       rd_en;
   csr_addr_t  rd_addr;
   logic       rd_valid;
   csr_word_t  rd_data;
   logic       rd_illegal;
   ret_class_t ret_class;
   logic       e_flag;
   ecause_t    e_cause;
   logic       ext_irq;

   integer      seed;
   int unsigned cycle_cnt = 0;
   // Edge numbers of the last read strobe and the last write
   int unsigned rd_cycle;
   int unsigned wr_cycle;

   // Reference model of the counters
   csr_word_t exp_inhibit;
   csr_word_t exp_minstret;
   csr_word_t exp_hpm [NUM_HPM];

   csr_unit #(.NUM_HPM(NUM_HPM)) UUT (
      .clk        (clk),
      .reset      (reset),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .rd_illegal (rd_illegal),
      .ret_class  (ret_class),
      .e_flag     (e_flag),
      .e_cause    (e_cause),
      .ext_irq    (ext_irq)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
      cycle_cnt <= cycle_cnt + 1;

   // ----------------------------------------------------------
   // Reporting and bus tasks
   // ----------------------------------------------------------
   task automatic stop_with_failure();
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic expect_value(input string name, input csr_word_t exp, input csr_word_t act);
      assert (act == exp)
      else
      begin
         $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic drive_write(input csr_addr_t addr, input csr_word_t data);
      @(posedge clk);
      wr_en   <= 1'b1;
      wr_addr <= addr;
      wr_data <= data;
      @(posedge clk);
      wr_en <= 1'b0;
      @(negedge clk);
      wr_cycle = cycle_cnt;
   endtask

   // Strobe lands on one edge, result is looked at on the following negedge
   task automatic do_read(input csr_addr_t addr, output csr_word_t data, output logic illegal);
      int waited;
      waited = 0;
      @(posedge clk);
      rd_en   <= 1'b1;
      rd_addr <= addr;
      @(posedge clk);
      rd_en <= 1'b0;
      @(negedge clk);
      rd_cycle = cycle_cnt;
      while (!rd_valid)
      begin
         waited++;
         assert (waited < 4)
         else
         begin
            $display("Read of CSR 0x%03h never returned rd_valid", addr);
            stop_with_failure();
         end
         @(negedge clk);
      end
      data    = rd_data;
      illegal = rd_illegal;
   endtask

   task automatic read_ok(input csr_addr_t addr, output csr_word_t data);
      logic illegal;
      do_read(addr, data, illegal);
      assert (!illegal)
      else
      begin
         $display("CSR 0x%03h is implemented but its read was flagged illegal", addr);
         stop_with_failure();
      end
   endtask

   task automatic check_read(input string name, input csr_addr_t addr, input csr_word_t exp);
      csr_word_t data;
      read_ok(addr, data);
      expect_value(name, exp, data);
   endtask

   task automatic check_illegal(input csr_addr_t addr);
      csr_word_t data;
      logic      illegal;
      // Nonzero misa first, so the illegal read has to clear rd_data
      check_read("misa before illegal read", ADDR_MISA, MISA_INIT);
      do_read(addr, data, illegal);
      assert (illegal)
      else
      begin
         $display("Unimplemented CSR 0x%03h was not flagged illegal", addr);
         stop_with_failure();
      end
      expect_value($sformatf("illegal read 0x%03h", addr), '0, data);
   endtask

   // Reset value, then all ones and all zeros through the writable mask
   task automatic check_word_reg(input string name, input csr_addr_t addr,
                                 input csr_word_t init, input csr_word_t wmask);
      check_read({name, " reset"}, addr, init);
      drive_write(addr, '1);
      check_read({name, " ones"}, addr, wmask | (init & ~wmask));
      drive_write(addr, '0);
      check_read({name, " zeros"}, addr, init & ~wmask);
   endtask

   // ----------------------------------------------------------
   // Event model and random traffic
   // ----------------------------------------------------------
   function automatic logic event_bit(input ev_sel_t sel, input ret_class_t rc,
                                      input logic ef, input ecause_t ec, input logic irq);
      if (sel >= 5'd1 && sel <= 5'd13)
         return rc[sel - 5'd1];
      case (sel)
         5'd14:   return ef && (ec == 4'd0);
         5'd15:   return ef && (ec == 4'd1);
         5'd16:   return ef && (ec == 4'd2);
         5'd17:   return rc[RET_BR] || rc[RET_JAL] || rc[RET_JALR];
         5'd18:   return ef && (ec == 4'd0 || ec == 4'd4 || ec == 4'd6);
         5'd19:   return rc != '0;
         5'd20:   return ef && (ec == 4'd3);
         5'd21:   return ef && (ec == 4'd6);
         5'd22:   return ef && (ec == 4'd8);
         5'd23:   return irq;
         default: return 1'b0;
      endcase
   endfunction

   task automatic run_traffic(input int cycles);
      logic [31:0] r;
      ret_class_t  rc;
      logic        ef;
      ecause_t     ec;
      logic        irq;
      for (int i = 0; i < cycles; i++)
      begin
         r   = $random(seed);
         // At most one class retires, three values in sixteen retire nothing
         rc  = (r[3:0] < NUM_RET_CLASS) ? (ret_class_t'(1) << r[3:0]) : '0;
         ef  = r[4];
         ec  = r[11:8];
         irq = r[12];
         @(posedge clk);
         ret_class <= rc;
         e_flag    <= ef;
         e_cause   <= ec;
         ext_irq   <= irq;
         if (!exp_inhibit[2] && rc != '0)
            exp_minstret++;
         for (int c = 0; c < NUM_HPM; c++)
         begin
            if (!exp_inhibit[c+3] && event_bit(HPM_SEL[c], rc, ef, ec, irq))
               exp_hpm[c]++;
         end
      end
      @(posedge clk);
      ret_class <= '0;
      e_flag    <= 1'b0;
      e_cause   <= '0;
      ext_irq   <= 1'b0;
   endtask

   task automatic check_counters(input string phase);
      check_read({phase, " minstret"}, ADDR_MINSTRET, exp_minstret);
      check_read({phase, " minstreth"}, ADDR_MINSTRETH, '0);
      for (int c = 0; c < NUM_HPM; c++)
         check_read($sformatf("%s mhpmcounter%0d", phase, c + 3),
                    csr_addr_t'(ADDR_MHPMCOUNTER_BASE + c), exp_hpm[c]);
   endtask

   // ----------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------
   initial
   begin
      csr_word_t   d0;
      csr_word_t   d1;
      int unsigned c0;
      logic [63:0] exp64;
      reset        = 1'b1;
      wr_en        = 1'b0;
      wr_addr      = '0;
      wr_data      = '0;
      rd_en        = 1'b0;
      rd_addr      = '0;
      ret_class    = '0;
      e_flag       = 1'b0;
      e_cause      = '0;
      ext_irq      = 1'b0;
      seed         = 32'h1f3a;
      exp_inhibit  = '0;
      exp_minstret = '0;
      for (int c = 0; c < NUM_HPM; c++)
         exp_hpm[c] = '0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      // Trap CSRs and mcountinhibit, writable bits per register
      check_word_reg("mstatus", ADDR_MSTATUS, MSTATUS_INIT, 32'h0000_1888);
      check_word_reg("misa", ADDR_MISA, MISA_INIT, 32'h0000_0000);
      check_word_reg("mie", ADDR_MIE, '0, 32'h0000_0888);
      check_word_reg("mtvec", ADDR_MTVEC, MTVEC_INIT, 32'hFFFF_FFFD);
      check_word_reg("mscratch", ADDR_MSCRATCH, '0, 32'hFFFF_FFFF);
      check_word_reg("mepc", ADDR_MEPC, '0, 32'hFFFF_FFFE);
      check_word_reg("mcause", ADDR_MCAUSE, '0, 32'hFFFF_FFFF);
      check_word_reg("mtval", ADDR_MTVAL, '0, 32'hFFFF_FFFF);
      check_word_reg("mip", ADDR_MIP, '0, 32'h0000_0888);
      // Counters 0, 2 and 3..6 exist with four hpm counters
      check_word_reg("mcountinhibit", ADDR_MCOUNTINHIBIT, '0, 32'h0000_007D);

      // Dropped registers and counters past NUM_HPM
      check_illegal(12'h302);
      check_illegal(12'h3A0);
      check_illegal(12'hF14);
      check_illegal(12'h7B0);
      check_illegal(csr_addr_t'(ADDR_MHPMEVENT_BASE + NUM_HPM));
      check_illegal(csr_addr_t'(ADDR_MHPMCOUNTER_BASE + NUM_HPM));

      // mcycle runs with the clock and stops when inhibited
      read_ok(ADDR_MCYCLE, d0);
      c0 = rd_cycle;
      repeat (7) @(posedge clk);
      read_ok(ADDR_MCYCLE, d1);
      expect_value("mcycle running", d0 + csr_word_t'(rd_cycle - c0), d1);
      drive_write(ADDR_MCOUNTINHIBIT, 32'h0000_0001);
      read_ok(ADDR_MCYCLE, d0);
      repeat (5) @(posedge clk);
      read_ok(ADDR_MCYCLE, d1);
      expect_value("mcycle inhibited", d0, d1);
      drive_write(ADDR_MCOUNTINHIBIT, '0);

      // Load mcycle close to a low-half wrap and watch the carry
      drive_write(ADDR_MCYCLEH, 32'h0000_0005);
      drive_write(ADDR_MCYCLE, 32'hFFFF_FFF0);
      c0 = wr_cycle;
      read_ok(ADDR_MCYCLE, d0);
      exp64 = 64'h0000_0005_FFFF_FFF0 + 64'(rd_cycle - c0 - 1);
      expect_value("mcycle low after write", exp64[31:0], d0);
      repeat (20) @(posedge clk);
      read_ok(ADDR_MCYCLEH, d1);
      exp64 = 64'h0000_0005_FFFF_FFF0 + 64'(rd_cycle - c0 - 1);
      expect_value("mcycleh after carry", exp64[63:32], d1);

      // Selectors keep five bits and read back zero-extended
      for (int c = 0; c < NUM_HPM; c++)
      begin
         drive_write(csr_addr_t'(ADDR_MHPMEVENT_BASE + c), 32'hFFFF_FFE0 | HPM_SEL[c]);
         check_read($sformatf("mhpmevent%0d", c + 3), csr_addr_t'(ADDR_MHPMEVENT_BASE + c),
                    csr_word_t'(HPM_SEL[c]));
      end

      // Random traffic with every counter enabled
      run_traffic(TRAFFIC_CYCLES);
      check_counters("enabled");

      // minstret and the second hpm counter held
      drive_write(ADDR_MCOUNTINHIBIT, 32'h0000_0014);
      exp_inhibit = 32'h0000_0014;
      check_read("mcountinhibit partial", ADDR_MCOUNTINHIBIT, exp_inhibit);
      run_traffic(TRAFFIC_CYCLES);
      check_counters("inhibited");

      $display("PASS: all tests");
      $finish;
   end

   // Watchdog
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      stop_with_failure();
   end

endmodule

`default_nettype wire

//--- verilog.f
hdl/csr_pkg.sv
hdl/csr_bus_if.sv
hdl/csr_field_reg.sv
hdl/csr_event_decode.sv
hdl/csr_machine_regs.sv
hdl/csr_counters.sv
hdl/csr_read_port.sv
hdl/csr_unit.sv
verif/csr_unit_checker.sv
verif/tb_csr_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir
verilator --binary --assert -Wno-fatal -f verilog.f --top-module tb_csr_unit -o sim_csr_unit
./obj_dir/sim_csr_unit 2>&1 | tee "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
   echo "Simulation reported errors"
   exit 1
fi
echo "Simulation finished without errors"
